// File: sources.f
+incdir+common
common/arc_io_pkg.sv
hw/io_decode.sv
ioc/ioc_kart.sv
ioc/ioc.sv
hw/latches.sv
hw/arc_io_top.sv
test/tb_clock.sv
test/arc_io_tb.sv

// File: Makefile
TOP := arc_io_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: test/arc_io_tb.sv
`timescale 1ns/1ps
`include "arc_io_macros.svh"

module arc_io_tb;
	import arc_io_pkg::*;

	// the tests take a few hundred cycles
	localparam int WATCHDOG_CYCLES = 2000;
	localparam logic [31:0] SEED = 32'h8bd329d8;

	logic clk, arst_n, cpu_ack, mem_ack, flybk, sirq_n, fdc_drq, fdc_irq;
	logic i2c_din, i2c_dout, i2c_clock, kbd_in_strobe, kbd_out_strobe;
	logic debug_led, irq, firq;
	logic [31:0] cpu_dat, mem_dat;
	logic [7:0] kbd_in_data, kbd_out_data;
	logic [4:0] joy0, joy1;
	cpu_req_t cpu_req;
	mem_req_t mem_req;
	floppy_ctl_t floppy;
	vid_enh_t vid_enh;

	int error_count = 0;
	int tests_run = 0;
	int tx_pulses = 0;
	logic [7:0] tx_last;
	logic [31:0] rng_state = SEED;
	logic [31:0] ram_words [logic [21:0]];
	logic [21:0] mem_last_adr;
	logic [31:0] mem_last_dat;
	logic [3:0] mem_last_sel;
	logic mem_last_we;

	tb_clock clock_i (.clk_o(clk), .arst_n_o(arst_n));

	arc_io_top dut_i (
		.clkcpu_i(clk), .arst_n_i(arst_n), .cpu_req_i(cpu_req), .cpu_ack_o(cpu_ack),
		.cpu_dat_o(cpu_dat), .mem_req_o(mem_req), .mem_ack_i(mem_ack), .mem_dat_i(mem_dat),
		.flybk_i(flybk), .sirq_n_i(sirq_n), .fdc_drq_i(fdc_drq), .fdc_irq_i(fdc_irq),
		.i2c_din_i(i2c_din), .i2c_dout_o(i2c_dout), .i2c_clock_o(i2c_clock),
		.kbd_in_data_i(kbd_in_data), .kbd_in_strobe_i(kbd_in_strobe),
		.kbd_out_data_o(kbd_out_data), .kbd_out_strobe_o(kbd_out_strobe),
		.joy0_i(joy0), .joy1_i(joy1), .floppy_o(floppy), .vid_enh_o(vid_enh),
		.debug_led_o(debug_led), .irq_o(irq), .firq_o(firq)
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// contents of a RAM word never written
	function automatic logic [31:0] fill_word(input logic [21:0] a);
		return {a[9:0], a} ^ 32'h5A5A_0000;
	endfunction

	function automatic logic [25:0] ioc_addr(input logic [4:0] idx);
		return {`ARC_IO_REGION, 1'b1, 2'b00, `ARC_IOC_BANK, 9'd0, idx, 2'b00};
	endfunction

	function automatic logic [25:0] lat_addr(input logic [4:0] idx);
		return {`ARC_IO_REGION, 1'b0, `ARC_LAT_SPEED, `ARC_LAT_BANK, 9'd0, idx, 2'b00};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		error_count++;
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// one Wishbone access
	// waited counts negedges up to the ack
	task automatic bus_cycle(input logic we, input logic [25:0] adr,
			input logic [31:0] wdat, input logic [3:0] sel,
			output logic [31:0] rdat, output int waited);
		step(1);
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we = we;
		cpu_req.sel = sel;
		cpu_req.adr.mem = adr;
		cpu_req.dat = wdat;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!cpu_ack && waited < 20);
		if (!cpu_ack) begin
			error_count++;
			$display("bus access to address %h was never acknowledged", adr);
		end
		rdat = cpu_dat;
		step(1);
		cpu_req.cyc = 1'b0;
		cpu_req.stb = 1'b0;
		cpu_req.we = 1'b0;
	endtask

	// byte access to an I/O block
	// ack is due one cycle after the strobe
	task automatic io_access(input logic we, input logic [25:0] adr, input logic [7:0] wv,
			output logic [31:0] rdat);
		int waited;
		bus_cycle(we, adr, {8'h00, wv, 16'h0000}, 4'b0100, rdat, waited);
		if (waited != 2) report_mismatch("I/O ack latency", waited, 32'd2);
		@(negedge clk);
		if (cpu_ack !== 1'b0)
			report_mismatch("cpu_ack_o after I/O ack", {31'd0, cpu_ack}, 32'd0);
	endtask

	task automatic ram_pass_through();
		logic [31:0] rd;
		int waited;
		tests_run++;
		bus_cycle(1'b1, 26'h200_0040, 32'hDEAD_BEEF, 4'hF, rd, waited);
		if (mem_last_adr !== 22'h00_0010)
			report_mismatch("mem_req_o.adr", {10'd0, mem_last_adr}, 32'h10);
		if (mem_last_dat !== 32'hDEAD_BEEF)
			report_mismatch("mem_req_o.dat", mem_last_dat, 32'hDEAD_BEEF);
		if (mem_last_we !== 1'b1) report_mismatch("mem_req_o.we", {31'd0, mem_last_we}, 32'd1);
		bus_cycle(1'b1, 26'h200_0040, 32'h1122_3344, 4'b0110, rd, waited);
		if (mem_last_sel !== 4'b0110)
			report_mismatch("mem_req_o.sel", {28'd0, mem_last_sel}, 32'h6);
		// only byte lanes 1 and 2 were replaced
		bus_cycle(1'b0, 26'h200_0040, 32'd0, 4'hF, rd, waited);
		if (rd !== 32'hDE22_33EF) report_mismatch("cpu_dat_o", rd, 32'hDE22_33EF);
		if (waited < 2 || waited > 5) begin
			error_count++;
			$display("RAM read took %0d cycles, outside the memory latency", waited);
		end
		bus_cycle(1'b0, 26'h212_3458, 32'd0, 4'hF, rd, waited);
		if (rd !== fill_word(22'h04_8D16))
			report_mismatch("cpu_dat_o", rd, fill_word(22'h04_8D16));
		bus_cycle(1'b0, 26'h000_0100, 32'd0, 4'hF, rd, waited);
		if (rd !== 32'hFFFF_FFFF) report_mismatch("cpu_dat_o unmapped", rd, 32'hFFFF_FFFF);
		if (waited != 2) report_mismatch("unmapped ack latency", waited, 32'd2);
	endtask

	task automatic latch_registers();
		logic [31:0] rd;
		logic [7:0] wv;
		tests_run++;
		@(negedge clk);
		if (floppy !== `LAT_A_RST)
			report_mismatch("floppy_o", {24'd0, floppy}, {24'd0, `LAT_A_RST});
		if (vid_enh !== 4'h0) report_mismatch("vid_enh_o", {28'd0, vid_enh}, 32'd0);
		wv = 8'h5E;
		io_access(1'b1, lat_addr(`LAT_REG_A), wv, rd);
		if (floppy !== wv) report_mismatch("floppy_o", {24'd0, floppy}, {24'd0, wv});
		if (debug_led !== (wv[6] | wv[0]))
			report_mismatch("debug_led_o", {31'd0, debug_led}, 32'd1);
		wv = 8'hB2;
		io_access(1'b1, lat_addr(`LAT_REG_A), wv, rd);
		if (debug_led !== (wv[6] | wv[0]))
			report_mismatch("debug_led_o", {31'd0, debug_led}, 32'd0);
		io_access(1'b0, lat_addr(`LAT_REG_A), 8'h00, rd);
		if (rd !== {24'd0, wv}) report_mismatch("latch A read", rd, {24'd0, wv});
		io_access(1'b1, lat_addr(`LAT_REG_C), 8'h0B, rd);
		if (vid_enh !== 4'hB) report_mismatch("vid_enh_o", {28'd0, vid_enh}, 32'hB);
		io_access(1'b0, lat_addr(`LAT_REG_C), 8'h00, rd);
		if (rd !== 32'h0B) report_mismatch("latch C read", rd, 32'h0B);
		step(1);
		joy0 = 5'h15;
		joy1 = 5'h0A;
		io_access(1'b0, lat_addr(`LAT_REG_JOY0), 8'h00, rd);
		if (rd !== 32'h15) report_mismatch("joy0 read", rd, 32'h15);
		io_access(1'b0, lat_addr(`LAT_REG_JOY1), 8'h00, rd);
		if (rd !== 32'h0A) report_mismatch("joy1 read", rd, 32'h0A);
	endtask

	task automatic control_port();
		logic [31:0] rd;
		tests_run++;
		step(1);
		i2c_din = 1'b1;
		@(negedge clk);
		if ({i2c_clock, i2c_dout} !== 2'b11)
			report_mismatch("i2c lines", {30'd0, i2c_clock, i2c_dout}, 32'h3);
		io_access(1'b0, ioc_addr(`IOC_REG_CTRL), 8'h00, rd);
		if (rd !== 32'h3F) report_mismatch("control read", rd, 32'h3F);
		io_access(1'b1, ioc_addr(`IOC_REG_CTRL), 8'h02, rd);
		if ({i2c_clock, i2c_dout} !== 2'b10)
			report_mismatch("i2c lines", {30'd0, i2c_clock, i2c_dout}, 32'h2);
		step(1);
		i2c_din = 1'b0;
		io_access(1'b0, ioc_addr(`IOC_REG_CTRL), 8'h00, rd);
		if (rd !== {24'd0, 2'b00, 5'b00001, 1'b0}) report_mismatch("control read", rd, 32'h02);
		io_access(1'b1, ioc_addr(`IOC_REG_CTRL), 8'h25, rd);
		if ({i2c_clock, i2c_dout} !== 2'b01)
			report_mismatch("i2c lines", {30'd0, i2c_clock, i2c_dout}, 32'h1);
		// bit 0 of the control register differs from the input pin here
		step(1);
		i2c_din = 1'b0;
		io_access(1'b0, ioc_addr(`IOC_REG_CTRL), 8'h00, rd);
		if (rd !== {24'd0, 2'b00, 5'b10010, 1'b0}) report_mismatch("control read", rd, 32'h24);
	endtask

	task automatic keyboard_bytes();
		logic [31:0] rd;
		int pulses_before;
		tests_run++;
		step(1);
		kbd_in_data = 8'hA7;
		kbd_in_strobe = 1'b1;
		step(1);
		kbd_in_strobe = 1'b0;
		io_access(1'b0, ioc_addr(`IOC_REG_IRQB_STAT), 8'h00, rd);
		if (rd !== 32'h80) report_mismatch("IRQB status", rd, 32'h80);
		io_access(1'b0, ioc_addr(`IOC_REG_KBD), 8'h00, rd);
		if (rd !== 32'hA7) report_mismatch("keyboard read", rd, 32'hA7);
		io_access(1'b0, ioc_addr(`IOC_REG_IRQB_STAT), 8'h00, rd);
		if (rd !== 32'h00) report_mismatch("IRQB status", rd, 32'h00);
		pulses_before = tx_pulses;
		io_access(1'b1, ioc_addr(`IOC_REG_KBD), 8'h3C, rd);
		step(2);
		@(negedge clk);
		if (tx_pulses - pulses_before != 1)
			report_mismatch("kbd_out_strobe_o pulses", tx_pulses - pulses_before, 32'd1);
		if (tx_last !== 8'h3C) report_mismatch("kbd_out_data_o", {24'd0, tx_last}, 32'h3C);
	endtask

	task automatic interrupt_sources();
		logic [31:0] rd;
		tests_run++;
		step(1);
		flybk = 1'b1;
		step(3);
		flybk = 1'b0;
		io_access(1'b0, ioc_addr(`IOC_REG_IRQA_STAT), 8'h00, rd);
		if (rd !== 32'h08) report_mismatch("IRQA status", rd, 32'h08);
		if (irq !== 1'b0) report_mismatch("irq_o masked", {31'd0, irq}, 32'd0);
		io_access(1'b1, ioc_addr(`IOC_REG_IRQA_MASK), 8'h08, rd);
		if (irq !== 1'b1) report_mismatch("irq_o", {31'd0, irq}, 32'd1);
		io_access(1'b1, ioc_addr(`IOC_REG_IRQA_REQ), 8'h08, rd);
		if (irq !== 1'b0) report_mismatch("irq_o after clear", {31'd0, irq}, 32'd0);
		io_access(1'b0, ioc_addr(`IOC_REG_IRQA_STAT), 8'h00, rd);
		if (rd !== 32'h00) report_mismatch("IRQA status", rd, 32'h00);
		// FIQ from the floppy controller lines
		step(1);
		fdc_drq = 1'b1;
		step(2);
		@(negedge clk);
		if (firq !== 1'b0) report_mismatch("firq_o masked", {31'd0, firq}, 32'd0);
		io_access(1'b0, ioc_addr(`IOC_REG_FIQ_STAT), 8'h00, rd);
		if (rd !== 32'h01) report_mismatch("FIQ status", rd, 32'h01);
		io_access(1'b1, ioc_addr(`IOC_REG_FIQ_MASK), 8'h01, rd);
		if (firq !== 1'b1) report_mismatch("firq_o", {31'd0, firq}, 32'd1);
		step(1);
		fdc_drq = 1'b0;
		fdc_irq = 1'b1;
		step(2);
		@(negedge clk);
		if (firq !== 1'b0) report_mismatch("firq_o masked", {31'd0, firq}, 32'd0);
		// status and mask differ, so no request bit
		io_access(1'b0, ioc_addr(`IOC_REG_FIQ_REQ), 8'h00, rd);
		if (rd !== 32'h00) report_mismatch("FIQ request", rd, 32'h00);
		io_access(1'b1, ioc_addr(`IOC_REG_FIQ_MASK), 8'h02, rd);
		if (firq !== 1'b1) report_mismatch("firq_o", {31'd0, firq}, 32'd1);
		io_access(1'b0, ioc_addr(`IOC_REG_FIQ_REQ), 8'h00, rd);
		if (rd !== 32'h02) report_mismatch("FIQ request", rd, 32'h02);
		step(1);
		fdc_irq = 1'b0;
		step(2);
		@(negedge clk);
		if (firq !== 1'b0) report_mismatch("firq_o idle", {31'd0, firq}, 32'd0);
		// sirq_n is active low
		step(1);
		sirq_n = 1'b0;
		step(2);
		io_access(1'b0, ioc_addr(`IOC_REG_IRQB_STAT), 8'h00, rd);
		if (rd !== 32'h02) report_mismatch("IRQB status", rd, 32'h02);
		if (irq !== 1'b0) report_mismatch("irq_o masked", {31'd0, irq}, 32'd0);
		io_access(1'b1, ioc_addr(`IOC_REG_IRQB_MASK), 8'h02, rd);
		if (irq !== 1'b1) report_mismatch("irq_o", {31'd0, irq}, 32'd1);
		step(1);
		sirq_n = 1'b1;
		step(2);
		@(negedge clk);
		if (irq !== 1'b0) report_mismatch("irq_o idle", {31'd0, irq}, 32'd0);
	endtask

	// memory with a random 1 to 4 cycle latency
	initial begin : memory_model
		logic req_seen;
		logic pending;
		int unsigned wait_left;
		logic [31:0] word;
		mem_ack = 1'b0;
		mem_dat = 32'd0;
		pending = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge clk);
			req_seen = mem_req.cyc & mem_req.stb;
			step(1);
			if (mem_ack) begin
				mem_ack = 1'b0;
			end else if (req_seen) begin
				if (!pending) begin
					rng_state = next_random(rng_state);
					wait_left = {30'd0, rng_state[1:0]} + 32'd1;
					pending = 1'b1;
				end
				wait_left = wait_left - 1;
				if (wait_left == 0) begin
					if (ram_words.exists(mem_req.adr))
						word = ram_words[mem_req.adr];
					else
						word = fill_word(mem_req.adr);
					if (mem_req.we) begin
						for (int b = 0; b < 4; b++)
							if (mem_req.sel[b]) word[8*b +: 8] = mem_req.dat[8*b +: 8];
						ram_words[mem_req.adr] = word;
					end else begin
						mem_dat = word;
					end
					mem_last_adr = mem_req.adr;
					mem_last_dat = mem_req.dat;
					mem_last_sel = mem_req.sel;
					mem_last_we = mem_req.we;
					pending = 1'b0;
					mem_ack = 1'b1;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (kbd_out_strobe) begin
			tx_pulses++;
			tx_last = kbd_out_data;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, run still going after %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		cpu_req = '0;
		flybk = 1'b0;
		sirq_n = 1'b1;
		fdc_drq = 1'b0;
		fdc_irq = 1'b0;
		i2c_din = 1'b0;
		kbd_in_data = 8'h00;
		kbd_in_strobe = 1'b0;
		joy0 = 5'h00;
		joy1 = 5'h00;
		@(posedge arst_n);
		step(2);
		ram_pass_through();
		latch_registers();
		control_port();
		keyboard_bytes();
		interrupt_sources();
		$display("tests run: %0d, errors: %0d", tests_run, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic arst_n_o
);

	// 10 ns period
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		arst_n_o = 1'b1;
	end

endmodule

// File: hw/arc_io_top.sv
`timescale 1ns/1ps

module arc_io_top (
	input  logic                    clkcpu_i,
	input  logic                    arst_n_i,
	input  arc_io_pkg::cpu_req_t    cpu_req_i,
	output logic                    cpu_ack_o,
	output logic [31:0]             cpu_dat_o,
	output arc_io_pkg::mem_req_t    mem_req_o,
	input  logic                    mem_ack_i,
	input  logic [31:0]             mem_dat_i,
	input  logic                    flybk_i,
	input  logic                    sirq_n_i,
	input  logic                    fdc_drq_i,
	input  logic                    fdc_irq_i,
	input  logic                    i2c_din_i,
	output logic                    i2c_dout_o,
	output logic                    i2c_clock_o,
	input  logic [7:0]              kbd_in_data_i,
	input  logic                    kbd_in_strobe_i,
	output logic [7:0]              kbd_out_data_o,
	output logic                    kbd_out_strobe_o,
	input  logic [4:0]              joy0_i,
	input  logic [4:0]              joy1_i,
	output arc_io_pkg::floppy_ctl_t floppy_o,
	output arc_io_pkg::vid_enh_t    vid_enh_o,
	output logic                    debug_led_o,
	output logic                    irq_o,
	output logic                    firq_o
);
	import arc_io_pkg::*;

	io_req_t    ioc_req;
	io_req_t    lat_req;
	logic [7:0] ioc_dat;
	logic [7:0] lat_dat;
	logic [5:0] ctrl;

	io_decode decode_i (
		.clkcpu_i  (clkcpu_i),
		.arst_n_i  (arst_n_i),
		.cpu_req_i (cpu_req_i),
		.cpu_ack_o (cpu_ack_o),
		.cpu_dat_o (cpu_dat_o),
		.mem_req_o (mem_req_o),
		.mem_ack_i (mem_ack_i),
		.mem_dat_i (mem_dat_i),
		.ioc_req_o (ioc_req),
		.lat_req_o (lat_req),
		.ioc_dat_i (ioc_dat),
		.lat_dat_i (lat_dat)
	);

	ioc ioc_i (
		.clkcpu_i         (clkcpu_i),
		.arst_n_i         (arst_n_i),
		.req_i            (ioc_req),
		.rdat_o           (ioc_dat),
		.flybk_i          (flybk_i),
		.sirq_n_i         (sirq_n_i),
		.fdc_drq_i        (fdc_drq_i),
		.fdc_irq_i        (fdc_irq_i),
		.i2c_din_i        (i2c_din_i),
		.ctrl_o           (ctrl),
		.irq_o            (irq_o),
		.firq_o           (firq_o),
		.kbd_in_data_i    (kbd_in_data_i),
		.kbd_in_strobe_i  (kbd_in_strobe_i),
		.kbd_out_data_o   (kbd_out_data_o),
		.kbd_out_strobe_o (kbd_out_strobe_o)
	);

	latches latches_i (
		.clkcpu_i    (clkcpu_i),
		.arst_n_i    (arst_n_i),
		.req_i       (lat_req),
		.rdat_o      (lat_dat),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.floppy_o    (floppy_o),
		.vid_enh_o   (vid_enh_o),
		.debug_led_o (debug_led_o)
	);

	// CMOS i2c lines sit on control bits 0 and 1
	assign i2c_dout_o  = ctrl[0];
	assign i2c_clock_o = ctrl[1];

endmodule

// File: hw/latches.sv
`timescale 1ns/1ps
`include "arc_io_macros.svh"

module latches (
	input  logic                    clkcpu_i,
	input  logic                    arst_n_i,
	input  arc_io_pkg::io_req_t     req_i,
	output logic [7:0]              rdat_o,
	input  logic [4:0]              joy0_i,
	input  logic [4:0]              joy1_i,
	output arc_io_pkg::floppy_ctl_t floppy_o,
	output arc_io_pkg::vid_enh_t    vid_enh_o,
	output logic                    debug_led_o
);
	import arc_io_pkg::*;

	floppy_ctl_t lat_a;
	logic [7:0]  lat_c;

	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			lat_a <= `LAT_A_RST;
			lat_c <= `LAT_C_RST;
		end else if (req_i.stb && req_i.we) begin
			case (req_i.reg_idx)
				`LAT_REG_A: lat_a <= req_i.wdat;
				`LAT_REG_C: lat_c <= req_i.wdat;
				default: ;
			endcase
		end
	end

	// joysticks are read back raw
	always_ff @(posedge clkcpu_i) begin
		if (req_i.stb && !req_i.we) begin
			case (req_i.reg_idx)
				`LAT_REG_A:    rdat_o <= lat_a;
				`LAT_REG_C:    rdat_o <= lat_c;
				`LAT_REG_JOY0: rdat_o <= {3'b0, joy0_i};
				`LAT_REG_JOY1: rdat_o <= {3'b0, joy1_i};
				default:       rdat_o <= 8'hFF;
			endcase
		end
	end

	assign floppy_o  = lat_a;
	// enhancer uses the low nibble of latch C
	assign vid_enh_o = lat_c[3:0];

	// LED off only with drive 0 selected and in use
	assign debug_led_o = lat_a.inuse_n | lat_a.drive_n[0];

endmodule

// File: ioc/ioc.sv
`timescale 1ns/1ps
`include "arc_io_macros.svh"

module ioc (
	input  logic                clkcpu_i,
	input  logic                arst_n_i,
	input  arc_io_pkg::io_req_t req_i,
	output logic [7:0]          rdat_o,
	input  logic                flybk_i,
	input  logic                sirq_n_i,
	input  logic                fdc_drq_i,
	input  logic                fdc_irq_i,
	input  logic                i2c_din_i,
	output logic [5:0]          ctrl_o,
	output logic                irq_o,
	output logic                firq_o,
	input  logic [7:0]          kbd_in_data_i,
	input  logic                kbd_in_strobe_i,
	output logic [7:0]          kbd_out_data_o,
	output logic                kbd_out_strobe_o
);
	import arc_io_pkg::*;

	logic       wr;
	logic       rd;
	logic       flybk_q;
	logic       flybk_lat;
	logic       kbd_full;
	logic [7:0] kbd_byte;
	logic [7:0] irqa_stat;
	logic [7:0] irqb_stat;
	logic [7:0] fiq_stat;
	logic [7:0] irqa_mask;
	logic [7:0] irqb_mask;
	logic [7:0] fiq_mask;
	logic [7:0] irqa_req;
	logic [7:0] irqb_req;
	logic [7:0] fiq_req;

	assign wr = req_i.stb & req_i.we;
	assign rd = req_i.stb & ~req_i.we;

	// control port and mask registers
	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_o    <= `IOC_CTRL_RST;
			irqa_mask <= 8'h00;
			irqb_mask <= 8'h00;
			fiq_mask  <= 8'h00;
		end else if (wr) begin
			case (req_i.reg_idx)
				`IOC_REG_CTRL:      ctrl_o    <= req_i.wdat[5:0];
				`IOC_REG_IRQA_MASK: irqa_mask <= req_i.wdat;
				`IOC_REG_IRQB_MASK: irqb_mask <= req_i.wdat;
				`IOC_REG_FIQ_MASK:  fiq_mask  <= req_i.wdat;
				default: ;
			endcase
		end
	end

	// flyback edge is latched, level sources are sampled
	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flybk_q   <= 1'b0;
			flybk_lat <= 1'b0;
			irqb_stat <= 8'h00;
			fiq_stat  <= 8'h00;
		end else begin
			flybk_q   <= flybk_i;
			irqb_stat <= {kbd_full, 5'b0, ~sirq_n_i, 1'b0};
			fiq_stat  <= {6'b0, fdc_irq_i, fdc_drq_i};
			if (flybk_i && !flybk_q)
				flybk_lat <= 1'b1;
			else if (wr && req_i.reg_idx == `IOC_REG_IRQA_REQ && req_i.wdat[3])
				flybk_lat <= 1'b0;
		end
	end

	assign irqa_stat = {4'b0, flybk_lat, 3'b0};

	assign irqa_req = irqa_stat & irqa_mask;
	assign irqb_req = irqb_stat & irqb_mask;
	assign fiq_req  = fiq_stat & fiq_mask;

	assign irq_o  = (|irqa_req) | (|irqb_req);
	assign firq_o = |fiq_req;

	// read byte is captured with the strobe, valid during ack
	always_ff @(posedge clkcpu_i) begin
		if (rd) begin
			case (req_i.reg_idx)
				`IOC_REG_CTRL:      rdat_o <= {2'b0, ctrl_o[5:1], i2c_din_i};
				`IOC_REG_KBD:       rdat_o <= kbd_byte;
				`IOC_REG_IRQA_STAT: rdat_o <= irqa_stat;
				`IOC_REG_IRQA_REQ:  rdat_o <= irqa_req;
				`IOC_REG_IRQA_MASK: rdat_o <= irqa_mask;
				`IOC_REG_IRQB_STAT: rdat_o <= irqb_stat;
				`IOC_REG_IRQB_REQ:  rdat_o <= irqb_req;
				`IOC_REG_IRQB_MASK: rdat_o <= irqb_mask;
				`IOC_REG_FIQ_STAT:  rdat_o <= fiq_stat;
				`IOC_REG_FIQ_REQ:   rdat_o <= fiq_req;
				`IOC_REG_FIQ_MASK:  rdat_o <= fiq_mask;
				default:            rdat_o <= 8'h00;
			endcase
		end
	end

	ioc_kart kart_i (
		.clkcpu_i    (clkcpu_i),
		.arst_n_i    (arst_n_i),
		.rx_data_i   (kbd_in_data_i),
		.rx_strobe_i (kbd_in_strobe_i),
		.rx_take_i   (rd && req_i.reg_idx == `IOC_REG_KBD),
		.rx_byte_o   (kbd_byte),
		.rx_full_o   (kbd_full),
		.tx_load_i   (wr && req_i.reg_idx == `IOC_REG_KBD),
		.tx_byte_i   (req_i.wdat),
		.tx_data_o   (kbd_out_data_o),
		.tx_strobe_o (kbd_out_strobe_o)
	);

endmodule

// File: ioc/ioc_kart.sv
`timescale 1ns/1ps

module ioc_kart (
	input  logic       clkcpu_i,
	input  logic       arst_n_i,
	input  logic [7:0] rx_data_i,
	input  logic       rx_strobe_i,
	input  logic       rx_take_i,
	output logic [7:0] rx_byte_o,
	output logic       rx_full_o,
	input  logic       tx_load_i,
	input  logic [7:0] tx_byte_i,
	output logic [7:0] tx_data_o,
	output logic       tx_strobe_o
);

	// receive flag, a new byte wins over a take in the same cycle
	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i)
			rx_full_o <= 1'b0;
		else if (rx_strobe_i)
			rx_full_o <= 1'b1;
		else if (rx_take_i)
			rx_full_o <= 1'b0;
	end

	// later bytes simply overwrite
	always_ff @(posedge clkcpu_i) begin
		if (rx_strobe_i)
			rx_byte_o <= rx_data_i;
	end

	always_ff @(posedge clkcpu_i) begin
		if (tx_load_i)
			tx_data_o <= tx_byte_i;
	end

	// one pulse per register write
	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i)
			tx_strobe_o <= 1'b0;
		else
			tx_strobe_o <= tx_load_i;
	end

	a_tx_strobe_single: assert property (@(posedge clkcpu_i) disable iff (!arst_n_i)
		tx_strobe_o |=> !tx_strobe_o);

endmodule

// File: hw/io_decode.sv
`timescale 1ns/1ps
`include "arc_io_macros.svh"

module io_decode (
	input  logic                 clkcpu_i,
	input  logic                 arst_n_i,
	input  arc_io_pkg::cpu_req_t cpu_req_i,
	output logic                 cpu_ack_o,
	output logic [31:0]          cpu_dat_o,
	output arc_io_pkg::mem_req_t mem_req_o,
	input  logic                 mem_ack_i,
	input  logic [31:0]          mem_dat_i,
	output arc_io_pkg::io_req_t  ioc_req_o,
	output arc_io_pkg::io_req_t  lat_req_o,
	input  logic [7:0]           ioc_dat_i,
	input  logic [7:0]           lat_dat_i
);
	import arc_io_pkg::*;

	cpu_addr_u adr;
	logic      ram_sel;
	logic      io_region;
	logic      ioc_sel;
	logic      lat_sel;
	logic      io_start;
	logic      io_busy;
	logic      io_ack;

	assign adr       = cpu_req_i.adr;
	assign ram_sel   = adr.mem[25:24] == `ARC_RAM_REGION;
	assign io_region = adr.io.region == `ARC_IO_REGION;
	assign ioc_sel   = io_region & adr.io.ioc_space & (adr.io.bank == `ARC_IOC_BANK);
	assign lat_sel   = io_region & (adr.io.bank == `ARC_LAT_BANK)
		& (adr.io.speed == `ARC_LAT_SPEED);

	// first cycle of a non-RAM access
	assign io_start = cpu_req_i.cyc & cpu_req_i.stb & ~ram_sel & ~io_busy;

	always_ff @(posedge clkcpu_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			io_busy <= 1'b0;
			io_ack  <= 1'b0;
		end else begin
			io_ack <= io_start;
			// held until the master drops stb
			if (io_start)
				io_busy <= 1'b1;
			else if (!(cpu_req_i.cyc && cpu_req_i.stb))
				io_busy <= 1'b0;
		end
	end

	assign mem_req_o = '{
		cyc: cpu_req_i.cyc & ram_sel,
		stb: cpu_req_i.stb & ram_sel,
		we:  cpu_req_i.we,
		sel: cpu_req_i.sel,
		adr: adr.mem[23:2],
		dat: cpu_req_i.dat
	};

	// write byte rides on data bits 23:16
	assign ioc_req_o = '{stb: io_start & ioc_sel, we: cpu_req_i.we,
		reg_idx: adr.io.reg_idx, wdat: cpu_req_i.dat[23:16]};
	assign lat_req_o = '{stb: io_start & lat_sel, we: cpu_req_i.we,
		reg_idx: adr.io.reg_idx, wdat: cpu_req_i.dat[23:16]};

	assign cpu_ack_o = ram_sel ? mem_ack_i : io_ack;

	always_comb begin
		if (ram_sel)
			cpu_dat_o = mem_dat_i;
		else if (ioc_sel)
			cpu_dat_o = {24'd0, ioc_dat_i};
		else if (lat_sel)
			cpu_dat_o = {24'd0, lat_dat_i};
		else
			cpu_dat_o = 32'hFFFF_FFFF;
	end

	a_ack_in_cycle: assert property (@(posedge clkcpu_i) disable iff (!arst_n_i)
		cpu_ack_o |-> cpu_req_i.cyc);

	a_io_ack_single: assert property (@(posedge clkcpu_i) disable iff (!arst_n_i)
		io_ack |=> !io_ack);

endmodule

// File: common/arc_io_pkg.sv
package arc_io_pkg;

	// I/O view of a cpu byte address
	typedef struct packed {
		logic [3:0] region;
		logic       ioc_space;
		logic [1:0] speed;
		logic [2:0] bank;
		logic [8:0] unused;
		logic [4:0] reg_idx;
		logic [1:0] byte_sel;
	} io_addr_t;

	// same 26 bits, read as memory or as I/O space
	typedef union packed {
		logic [25:0] mem;
		io_addr_t    io;
	} cpu_addr_u;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		cpu_addr_u   adr;
		logic [31:0] dat;
	} cpu_req_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [23:2] adr;
		logic [31:0] dat;
	} mem_req_t;

	// byte wide request towards an I/O block
	typedef struct packed {
		logic       stb;
		logic       we;
		logic [4:0] reg_idx;
		logic [7:0] wdat;
	} io_req_t;

	// latch A, bit 7 down to bit 0
	typedef struct packed {
		logic       reset_n;
		logic       inuse_n;
		logic       motor;
		logic       side;
		logic [3:0] drive_n;
	} floppy_ctl_t;

	typedef struct packed {
		logic [1:0] syncpol;
		logic [1:0] baseclk;
	} vid_enh_t;

endpackage

// File: common/arc_io_macros.svh
`ifndef ARC_IO_MACROS_SVH
`define ARC_IO_MACROS_SVH

// address map
`define ARC_RAM_REGION      2'd2
`define ARC_IO_REGION       4'b1100
`define ARC_IOC_BANK        3'd0
`define ARC_LAT_BANK        3'd5
`define ARC_LAT_SPEED       2'd2

// IOC register indices
`define IOC_REG_CTRL        5'd0
`define IOC_REG_KBD         5'd1
`define IOC_REG_IRQA_STAT   5'd4
`define IOC_REG_IRQA_REQ    5'd5
`define IOC_REG_IRQA_MASK   5'd6
`define IOC_REG_IRQB_STAT   5'd8
`define IOC_REG_IRQB_REQ    5'd9
`define IOC_REG_IRQB_MASK   5'd10
`define IOC_REG_FIQ_STAT    5'd12
`define IOC_REG_FIQ_REQ     5'd13
`define IOC_REG_FIQ_MASK    5'd14

// external latch indices
`define LAT_REG_A           5'd0
`define LAT_REG_C           5'd2
`define LAT_REG_JOY0        5'd4
`define LAT_REG_JOY1        5'd5

// reset values
`define IOC_CTRL_RST        6'h3F
`define LAT_A_RST           8'hFF
`define LAT_C_RST           8'h00

`endif
